//--- rtl/switch_pkg.sv
`default_nettype none

package switch_pkg;

	localparam int NUM_STREAMS = 8; // External sample streams.

	localparam int AXIL_ADDR_W = 4;  // Byte address into the register block.
	localparam int AXIL_DATA_W = 32; // Register word width.

	typedef logic [3:0]                     sel_t;        // 0..7 stream, 8 local.
	typedef logic [9:0]                     dwell_t;      // Dwell cap and timer.
	typedef logic [NUM_STREAMS-1:0]         mask_t;       // One bit per stream.
	typedef logic [15:0]                    sample_t;     // Sample word.
	typedef logic [$clog2(NUM_STREAMS)-1:0] stream_idx_t; // Stream pointer.

	localparam sel_t SEL_LOCAL = 4'd8; // Local source code.

	localparam logic [AXIL_ADDR_W-1:0] REG_DWELL  = 4'h0; // Dwell cap, RW.
	localparam logic [AXIL_ADDR_W-1:0] REG_OPEN   = 4'h4; // Open mask, RW.
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 4'h8; // Status, RO.

	localparam dwell_t DWELL_RESET = 10'd799; // About 800 cycles per stream.
	localparam mask_t  OPEN_RESET  = '1;      // All streams open.

	localparam logic [1:0] RESP_OKAY   = 2'b00; // Normal access.
	localparam logic [1:0] RESP_SLVERR = 2'b10; // Unmapped address.

	// Scheduler scan state.
	typedef enum logic
	{
		SCAN_OFF, // Link down, local source.
		SCAN_ON   // Link up, rotating.
	} scan_state_t;

endpackage

`default_nettype wire

//--- rtl/switch_regs.sv
`default_nettype none

module switch_regs (
	input  logic                                clock,
	input  logic                                rst_n,
	// Write address channel.
	input  logic [switch_pkg::AXIL_ADDR_W-1:0]  awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	// Write data channel.
	input  logic [switch_pkg::AXIL_DATA_W-1:0]  wdata,
	input  logic [switch_pkg::AXIL_DATA_W/8-1:0] wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	// Write response channel.
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  logic                                bready,
	// Read address channel.
	input  logic [switch_pkg::AXIL_ADDR_W-1:0]  araddr,
	input  logic                                arvalid,
	output logic                                arready,
	// Read data channel.
	output logic [switch_pkg::AXIL_DATA_W-1:0]  rdata,
	output logic [1:0]                          rresp,
	output logic                                rvalid,
	input  logic                                rready,
	// Status inputs.
	input  switch_pkg::sel_t                    sel,
	input  logic                                bt_state,
	// Configuration to the scheduler.
	output switch_pkg::dwell_t                  dwell_cap,
	output switch_pkg::mask_t                   open_mask
);

	logic                               wr_accept;     // Write handshake this cycle.
	logic                               rd_accept;     // Read handshake this cycle.
	logic                               wr_hit_dwell;  // Write targets DWELL.
	logic                               wr_hit_open;   // Write targets OPEN.
	logic                               wr_hit_status; // Write targets STATUS.
	logic                               wr_mapped;     // Any known write address.
	logic [switch_pkg::AXIL_DATA_W-1:0] status_word;   // Live status value.
	logic [switch_pkg::AXIL_DATA_W-1:0] rd_word;       // Read mux output.
	logic                               rd_err;        // Unknown read address.

	// Address and data are taken together, only with no response in flight.
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready   = wr_accept; // Both ready in the accept cycle.
	assign wready    = wr_accept;

	assign rd_accept = arvalid && !rvalid; // One read outstanding.
	assign arready   = rd_accept;

	assign wr_hit_dwell  = (awaddr == switch_pkg::REG_DWELL);
	assign wr_hit_open   = (awaddr == switch_pkg::REG_OPEN);
	assign wr_hit_status = (awaddr == switch_pkg::REG_STATUS); // Accepted, no effect.
	assign wr_mapped     = wr_hit_dwell || wr_hit_open || wr_hit_status;

	// Bits 3:0 selection, bit 4 link state.
	assign status_word = {{(switch_pkg::AXIL_DATA_W-5){1'b0}}, bt_state, sel};

	// Configuration registers with byte strobes.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			dwell_cap <= switch_pkg::DWELL_RESET;
			open_mask <= switch_pkg::OPEN_RESET;
		end
		else if (wr_accept)
		begin
			if (wr_hit_dwell)
			begin
				if (wstrb[0])
				begin
					dwell_cap[7:0] <= wdata[7:0]; // Low byte.
				end
				if (wstrb[1])
				begin
					dwell_cap[9:8] <= wdata[9:8]; // Top two bits.
				end
			end
			if (wr_hit_open && wstrb[0])
			begin
				open_mask <= wdata[7:0]; // Mask fits in byte 0.
			end
		end
	end

	// Write response valid.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			bvalid <= 1'b0;
		end
		else if (wr_accept)
		begin
			bvalid <= 1'b1; // Rises the cycle after accept.
		end
		else if (bready)
		begin
			bvalid <= 1'b0; // Held until taken.
		end
	end

	// Write response code.
	always_ff @(posedge clock)
	begin
		if (wr_accept)
		begin
			bresp <= wr_mapped ? switch_pkg::RESP_OKAY : switch_pkg::RESP_SLVERR;
		end
	end

	// Read decode.
	always_comb
	begin
		rd_word = '0;
		rd_err  = 1'b0;
		case (araddr)
			switch_pkg::REG_DWELL:
			begin
				rd_word[$bits(switch_pkg::dwell_t)-1:0] = dwell_cap;
			end
			switch_pkg::REG_OPEN:
			begin
				rd_word[$bits(switch_pkg::mask_t)-1:0] = open_mask;
			end
			switch_pkg::REG_STATUS:
			begin
				rd_word = status_word;
			end
			default:
			begin
				rd_err = 1'b1; // Reads as zero.
			end
		endcase
	end

	// Read response valid.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			rvalid <= 1'b0;
		end
		else if (rd_accept)
		begin
			rvalid <= 1'b1;
		end
		else if (rready)
		begin
			rvalid <= 1'b0;
		end
	end

	// Read data and code, captured at accept.
	always_ff @(posedge clock)
	begin
		if (rd_accept)
		begin
			rdata <= rd_word;
			rresp <= rd_err ? switch_pkg::RESP_SLVERR : switch_pkg::RESP_OKAY;
		end
	end

endmodule

`default_nettype wire

//--- rtl/master_switch.sv
`default_nettype none

module master_switch (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               bt_state,  // Link up.
	input  switch_pkg::dwell_t dwell_cap, // Last timer value of a dwell.
	input  switch_pkg::mask_t  open_mask, // Streams allowed in the rotation.
	output switch_pkg::sel_t   sel        // Registered selection code.
);

	localparam switch_pkg::stream_idx_t PTR_LAST =
		switch_pkg::stream_idx_t'(switch_pkg::NUM_STREAMS - 1); // Scan starts after it.

	switch_pkg::scan_state_t state;     // Scan state.
	switch_pkg::dwell_t      timer;     // Dwell timer.
	switch_pkg::stream_idx_t ptr;       // Last stream granted.
	switch_pkg::dwell_t      timer_cur; // Timer seen this cycle.
	switch_pkg::stream_idx_t ptr_cur;   // Pointer seen this cycle.
	logic                    expire;    // Dwell period ends this cycle.
	logic                    nxt_found; // Some stream is open.
	switch_pkg::stream_idx_t nxt_idx;   // First open stream after ptr_cur.

	// A fresh scan always begins from a clear timer and the top pointer.
	always_comb
	begin
		if (state == switch_pkg::SCAN_OFF)
		begin
			timer_cur = '0;
			ptr_cur   = PTR_LAST;
		end
		else
		begin
			timer_cur = timer;
			ptr_cur   = ptr;
		end
	end

	// Equality only. A cap lowered under the timer waits for the wrap.
	assign expire = (timer_cur == dwell_cap);

	// Circular search from ptr_cur plus one.
	always_comb
	begin
		switch_pkg::stream_idx_t cand; // Candidate index.
		nxt_found = 1'b0;
		nxt_idx   = ptr_cur;
		cand      = ptr_cur;
		for (int i = 1; i <= switch_pkg::NUM_STREAMS; i++)
		begin
			cand = ptr_cur + switch_pkg::stream_idx_t'(i); // Wraps modulo 8.
			if (!nxt_found && open_mask[cand])
			begin
				nxt_found = 1'b1; // First hit wins.
				nxt_idx   = cand;
			end
		end
	end

	// Scan state, timer, pointer and selection.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state <= switch_pkg::SCAN_OFF;
			timer <= '0;
			ptr   <= PTR_LAST;
			sel   <= switch_pkg::SEL_LOCAL;
		end
		else if (!bt_state)
		begin
			state <= switch_pkg::SCAN_OFF; // Link down.
			timer <= '0;                   // Held at zero.
			ptr   <= PTR_LAST;             // Next scan begins at stream 0.
			sel   <= switch_pkg::SEL_LOCAL;
		end
		else
		begin
			state <= switch_pkg::SCAN_ON;
			if (expire)
			begin
				timer <= '0; // New dwell period.
				if (nxt_found)
				begin
					sel <= switch_pkg::sel_t'(nxt_idx);
					ptr <= nxt_idx; // Remember the grant.
				end
				else
				begin
					sel <= switch_pkg::SEL_LOCAL; // Empty mask.
					ptr <= ptr_cur;               // Resume after the last grant.
				end
			end
			else
			begin
				timer <= timer_cur + 1'b1; // Count every linked cycle.
				ptr   <= ptr_cur;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/stream_mux.sv
`default_nettype none

module stream_mux (
	input  logic                                              clock,
	input  logic                                              rst_n,
	input  switch_pkg::sel_t                                  sel,          // Source code.
	input  switch_pkg::sample_t [switch_pkg::NUM_STREAMS-1:0] stream_data,  // Packed samples.
	input  switch_pkg::mask_t                                 stream_valid, // Per stream.
	input  switch_pkg::sample_t                               local_data,   // Local sample.
	input  logic                                              local_valid,
	output switch_pkg::sample_t                               out_data,     // One cycle late.
	output logic                                              out_valid
);

	switch_pkg::stream_idx_t idx;        // Stream part of sel.
	switch_pkg::sample_t     pick_data;  // Selected sample.
	logic                    pick_valid; // Selected valid.

	assign idx = sel[$bits(switch_pkg::stream_idx_t)-1:0];

	// Nine-way select. Codes above 8 give an idle output.
	always_comb
	begin
		if (sel == switch_pkg::SEL_LOCAL)
		begin
			pick_data  = local_data;
			pick_valid = local_valid;
		end
		else if (sel < switch_pkg::NUM_STREAMS)
		begin
			pick_data  = stream_data[idx];
			pick_valid = stream_valid[idx];
		end
		else
		begin
			pick_data  = '0;
			pick_valid = 1'b0;
		end
	end

	// Output valid.
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= pick_valid;
		end
	end

	// Sample register.
	always_ff @(posedge clock)
	begin
		out_data <= pick_data;
	end

endmodule

`default_nettype wire

//--- rtl/switch_top.sv
`default_nettype none

module switch_top (
	input  logic                                              clock,
	input  logic                                              rst_n,
	input  logic                                              bt_state,
	// Register bus.
	input  logic [switch_pkg::AXIL_ADDR_W-1:0]                awaddr,
	input  logic                                              awvalid,
	output logic                                              awready,
	input  logic [switch_pkg::AXIL_DATA_W-1:0]                wdata,
	input  logic [switch_pkg::AXIL_DATA_W/8-1:0]              wstrb,
	input  logic                                              wvalid,
	output logic                                              wready,
	output logic [1:0]                                        bresp,
	output logic                                              bvalid,
	input  logic                                              bready,
	input  logic [switch_pkg::AXIL_ADDR_W-1:0]                araddr,
	input  logic                                              arvalid,
	output logic                                              arready,
	output logic [switch_pkg::AXIL_DATA_W-1:0]                rdata,
	output logic [1:0]                                        rresp,
	output logic                                              rvalid,
	input  logic                                              rready,
	// Sample path.
	input  switch_pkg::sample_t [switch_pkg::NUM_STREAMS-1:0] stream_data,
	input  switch_pkg::mask_t                                 stream_valid,
	input  switch_pkg::sample_t                               local_data,
	input  logic                                              local_valid,
	output switch_pkg::sample_t                               out_data,
	output logic                                              out_valid,
	output switch_pkg::sel_t                                  cur_sel // Current source.
);

	switch_pkg::dwell_t dwell_cap; // Register block to scheduler.
	switch_pkg::mask_t  open_mask;

	switch_regs u_regs (
		.clock     (clock),
		.rst_n     (rst_n),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.sel       (cur_sel),  // Status readback.
		.bt_state  (bt_state),
		.dwell_cap (dwell_cap),
		.open_mask (open_mask)
	);

	master_switch u_sched (
		.clock     (clock),
		.rst_n     (rst_n),
		.bt_state  (bt_state),
		.dwell_cap (dwell_cap),
		.open_mask (open_mask),
		.sel       (cur_sel)
	);

	stream_mux u_mux (
		.clock        (clock),
		.rst_n        (rst_n),
		.sel          (cur_sel),
		.stream_data  (stream_data),
		.stream_valid (stream_valid),
		.local_data   (local_data),
		.local_valid  (local_valid),
		.out_data     (out_data),
		.out_valid    (out_valid)
	);

endmodule

`default_nettype wire

//--- tests/switch_asserts.sv
`default_nettype none

module switch_asserts (
	input logic             clock,
	input logic             rst_n,
	input logic             bvalid, // Write response valid.
	input logic             bready,
	input logic             rvalid, // Read response valid.
	input logic             rready,
	input switch_pkg::sel_t sel     // Selection code.
);

	// Responses stay up until the master takes them.
	a_bvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	a_sel_range: assert property (@(posedge clock) disable iff (!rst_n)
		sel <= switch_pkg::SEL_LOCAL)
		else $error("selection code above the local code");

endmodule

bind switch_regs switch_asserts u_regs_asserts (.clock(clock), .rst_n(rst_n), .bvalid(bvalid),
	.bready(bready), .rvalid(rvalid), .rready(rready), .sel(sel));

bind master_switch switch_asserts u_sched_asserts (.clock(clock), .rst_n(rst_n), .bvalid(1'b0),
	.bready(1'b1), .rvalid(1'b0), .rready(1'b1), .sel(sel));

`default_nettype wire

//--- tests/tb_switch_top.sv
`default_nettype none

module tb_switch_top;

	localparam int MAX_CYCLES = 20000; // All tests with margin.

	logic                                              clock;
	logic                                              rst_n;
	logic                                              bt_state;
	logic [switch_pkg::AXIL_ADDR_W-1:0]                awaddr;
	logic                                              awvalid;
	logic                                              awready;
	logic [switch_pkg::AXIL_DATA_W-1:0]                wdata;
	logic [switch_pkg::AXIL_DATA_W/8-1:0]              wstrb;
	logic                                              wvalid;
	logic                                              wready;
	logic [1:0]                                        bresp;
	logic                                              bvalid;
	logic                                              bready;
	logic [switch_pkg::AXIL_ADDR_W-1:0]                araddr;
	logic                                              arvalid;
	logic                                              arready;
	logic [switch_pkg::AXIL_DATA_W-1:0]                rdata;
	logic [1:0]                                        rresp;
	logic                                              rvalid;
	logic                                              rready;
	switch_pkg::sample_t [switch_pkg::NUM_STREAMS-1:0] stream_data;
	switch_pkg::mask_t                                 stream_valid;
	switch_pkg::sample_t                               local_data;
	logic                                              local_valid;
	switch_pkg::sample_t                               out_data;
	logic                                              out_valid;
	switch_pkg::sel_t                                  cur_sel;

	switch_pkg::dwell_t      m_dwell;                          // Cap seen by the scheduler.
	switch_pkg::mask_t       m_mask;                           // Mask seen by the scheduler.
	switch_pkg::dwell_t      m_timer;                          // Model dwell timer.
	switch_pkg::stream_idx_t m_ptr;                            // Model last grant.
	switch_pkg::sel_t        exp_sel;                          // Expected cur_sel.
	switch_pkg::sample_t     exp_data;                         // Expected out_data.
	logic                    exp_valid;
	logic                    armed = 1'b0;                     // Data compare live.
	int                      errors = 0;
	int                      start_errors = 0;
	int                      passed = 0;
	int                      failed = 0;
	int                      cycles = 0;
	string                   test_name = "reset";
	switch_pkg::sel_t        seq_q[$];                         // Selection changes seen.
	int                      len_q[$];                         // Run length before each change.
	int                      run_len = 0;
	switch_pkg::sel_t        last_sel = switch_pkg::SEL_LOCAL;

	switch_top u_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock; // Period 8.
	end

	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// Fresh samples each cycle. Stream index in the top nibble keeps them distinct.
	always @(posedge clock)
	begin
		logic [31:0] r;
		#1;
		for (int i = 0; i < switch_pkg::NUM_STREAMS; i++)
		begin
			r = $urandom;
			stream_data[i] = {i[3:0], r[11:0]};
		end
		r = $urandom;
		stream_valid = r[7:0];
		local_valid  = r[8];
		local_data   = {4'h8, r[27:16]}; // Local tagged with 8.
	end

	// Next code at a dwell expiry. Circular search after the last grant.
	function automatic switch_pkg::sel_t model_next_sel(input switch_pkg::sel_t cur,
		input switch_pkg::stream_idx_t ptr, input switch_pkg::mask_t mask);
		int start;
		int idx;
		start = (cur == switch_pkg::SEL_LOCAL) ? int'(ptr) : int'(cur); // Local keeps ptr.
		for (int k = 1; k <= switch_pkg::NUM_STREAMS; k++)
		begin
			idx = (start + k) % switch_pkg::NUM_STREAMS;
			if (mask[idx])
				return switch_pkg::sel_t'(idx);
		end
		return switch_pkg::SEL_LOCAL; // Nothing open.
	endfunction

	task automatic flag_mismatch(input string what, input logic [31:0] want, input logic [31:0] got);
		errors++;
		$display("Error %s: %s expected 0x%0h actual 0x%0h", test_name, what, want, got);
	endtask

	// Compare, then step the model to the state after the next edge.
	always @(negedge clock)
	begin
		switch_pkg::sel_t nxt;
		if (!rst_n)
		begin
			m_dwell = switch_pkg::DWELL_RESET;
			m_mask  = switch_pkg::OPEN_RESET;
			m_timer = '0;
			m_ptr   = 3'd7;
			exp_sel = switch_pkg::SEL_LOCAL;
			armed   = 1'b0;
		end
		else
		begin
			if (cur_sel !== exp_sel)
				flag_mismatch("cur_sel", exp_sel, cur_sel);
			if (armed && (out_data !== exp_data || out_valid !== exp_valid))
				flag_mismatch("out_valid,out_data", {exp_valid, exp_data}, {out_valid, out_data});
			if (cur_sel != last_sel)
			begin
				seq_q.push_back(cur_sel);
				len_q.push_back(run_len);
				run_len = 1;
			end
			else
				run_len++;
			last_sel  = cur_sel;
			exp_data  = (exp_sel == switch_pkg::SEL_LOCAL) ? local_data : stream_data[exp_sel[2:0]];
			exp_valid = (exp_sel == switch_pkg::SEL_LOCAL) ? local_valid : stream_valid[exp_sel[2:0]];
			armed     = 1'b1;
			if (!bt_state)
			begin
				m_timer = '0; // Link down parks the scan.
				m_ptr   = 3'd7;
				exp_sel = switch_pkg::SEL_LOCAL;
			end
			else if (m_timer == m_dwell)
			begin
				nxt = model_next_sel(exp_sel, m_ptr, m_mask);
				if (nxt != switch_pkg::SEL_LOCAL)
					m_ptr = nxt[2:0];
				exp_sel = nxt;
				m_timer = '0;
			end
			else
				m_timer = m_timer + 1'b1;
		end
	end

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [1:0] want_resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clock);
		while (!awready)
			@(negedge clock);
		if (wready !== 1'b1)
			flag_mismatch("wready", 1'b1, wready); // Both ready together.
		@(posedge clock); // Accept edge.
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		if (addr == switch_pkg::REG_DWELL)
			m_dwell = data[9:0]; // Scheduler sees it from the next edge.
		if (addr == switch_pkg::REG_OPEN)
			m_mask = data[7:0];
		@(negedge clock);
		while (!bvalid)
			@(negedge clock);
		if (bresp !== want_resp)
			flag_mismatch("bresp", want_resp, bresp);
		@(posedge clock);
		#1;
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clock);
		while (!arready)
			@(negedge clock);
		@(posedge clock);
		#1;
		arvalid = 1'b0;
		rready  = 1'b1;
		@(negedge clock);
		while (!rvalid)
			@(negedge clock);
		data = rdata;
		resp = rresp;
		@(posedge clock);
		#1;
		rready = 1'b0;
	endtask

	task automatic expect_read(input logic [3:0] addr, input logic [31:0] want);
		logic [31:0] got;
		logic [1:0]  resp;
		read_reg(addr, got, resp);
		if (resp !== switch_pkg::RESP_OKAY)
			flag_mismatch("rresp", switch_pkg::RESP_OKAY, resp);
		if (got !== want)
			flag_mismatch("rdata", want, got);
	endtask

	task automatic wait_changes(input int n);
		while (seq_q.size() < n)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		start_errors = errors;
	endtask

	task automatic end_test();
		if (errors == start_errors)
		begin
			passed++;
			$display("PASS %s", test_name);
		end
		else
		begin
			failed++;
			$display("FAIL %s with %0d errors", test_name, errors - start_errors);
		end
	endtask

	initial
	begin
		int unsigned             seed;
		logic [31:0]             got;
		logic [1:0]              resp;
		switch_pkg::stream_idx_t grant;
		switch_pkg::sel_t        sparse_want [4];
		seed = 32'h260bc680;
		void'($urandom(seed));
		sparse_want = '{4'd0, 4'd2, 4'd5, 4'd0}; // Mask 0x25 from stream 0.
		rst_n        = 1'b0;
		bt_state     = 1'b0;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wstrb        = '0;
		wvalid       = 1'b0;
		bready       = 1'b0;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		stream_data  = '0;
		stream_valid = '0;
		local_data   = '0;
		local_valid  = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		rst_n = 1'b1;

		begin_test("reset_readback");
		expect_read(switch_pkg::REG_DWELL, 32'd799);
		expect_read(switch_pkg::REG_OPEN, 32'hff);
		write_reg(switch_pkg::REG_DWELL, 32'h155, switch_pkg::RESP_OKAY);
		write_reg(switch_pkg::REG_OPEN, 32'h5a, switch_pkg::RESP_OKAY);
		expect_read(switch_pkg::REG_DWELL, 32'h155);
		expect_read(switch_pkg::REG_OPEN, 32'h5a);
		write_reg(switch_pkg::REG_STATUS, 32'h1f, switch_pkg::RESP_OKAY); // Read only.
		expect_read(switch_pkg::REG_STATUS, 32'h8); // Link down, local code.
		end_test();

		begin_test("unmapped_address");
		write_reg(4'hc, 32'h3, switch_pkg::RESP_SLVERR);
		read_reg(4'hc, got, resp);
		if (resp !== switch_pkg::RESP_SLVERR)
			flag_mismatch("rresp", switch_pkg::RESP_SLVERR, resp);
		expect_read(switch_pkg::REG_DWELL, 32'h155);
		expect_read(switch_pkg::REG_OPEN, 32'h5a);
		end_test();

		begin_test("link_down");
		repeat (30) @(posedge clock); // Model compares every cycle.
		#1;
		end_test();

		begin_test("full_rotation");
		write_reg(switch_pkg::REG_DWELL, 32'd3, switch_pkg::RESP_OKAY);
		write_reg(switch_pkg::REG_OPEN, 32'hff, switch_pkg::RESP_OKAY);
		seq_q.delete();
		len_q.delete();
		bt_state = 1'b1;
		wait_changes(9);
		for (int k = 0; k < 9; k++)
		begin
			if (seq_q[k] !== switch_pkg::sel_t'(k % 8))
				flag_mismatch("sequence step", k % 8, seq_q[k]);
			if (k > 0 && len_q[k] != 4)
				flag_mismatch("run length", 4, len_q[k]); // Dwell 3 plus one.
		end
		end_test();

		begin_test("sparse_mask");
		bt_state = 1'b0;
		write_reg(switch_pkg::REG_OPEN, 32'h25, switch_pkg::RESP_OKAY);
		seq_q.delete();
		bt_state = 1'b1;
		wait_changes(4);
		for (int k = 0; k < 4; k++)
		begin
			if (seq_q[k] !== sparse_want[k])
				flag_mismatch("sequence step", sparse_want[k], seq_q[k]);
		end
		end_test();

		begin_test("empty_mask");
		seq_q.delete();
		write_reg(switch_pkg::REG_OPEN, 32'h0, switch_pkg::RESP_OKAY);
		while (seq_q.size() == 0 || seq_q[seq_q.size()-1] != switch_pkg::SEL_LOCAL)
		begin
			@(posedge clock);
			#1;
		end
		grant = m_ptr; // Last stream granted before the mask emptied.
		seq_q.delete();
		repeat (12) @(posedge clock); // Three dwells stay local.
		#1;
		if (seq_q.size() != 0)
			$display("Error %s: selection left the local source with an empty mask", test_name);
		if (seq_q.size() != 0)
			errors++;
		write_reg(switch_pkg::REG_OPEN, 32'h25, switch_pkg::RESP_OKAY);
		wait_changes(1);
		if (seq_q[0] !== model_next_sel(switch_pkg::SEL_LOCAL, grant, 8'h25))
			flag_mismatch("resume", model_next_sel(switch_pkg::SEL_LOCAL, grant, 8'h25), seq_q[0]);
		end_test();

		bt_state = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		$display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
rtl/switch_pkg.sv
rtl/switch_regs.sv
rtl/master_switch.sv
rtl/stream_mux.sv
rtl/switch_top.sv
tests/switch_asserts.sv
tests/tb_switch_top.sv
